// ==== Makefile ====
# Verilator build and run for the PCM bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_pcm_bridge
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

# the run passes only if the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
src/audio_pkg.sv
src/i2s_rx.sv
src/i2s_tx.sv
src/spdif_framer.sv
src/biphase_encoder.sv
src/pcm_bridge_top.sv
tb/tb_pcm_bridge.sv

// ==== src/audio_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, types and S/PDIF constants for the PCM audio bridge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package audio_pkg;

   // one PCM word as carried on the I2S link
   localparam int unsigned SAMPLE_W = 32;

   // bck cycles per stereo I2S frame, also cells per S/PDIF subframe
   localparam int unsigned FRAME_BITS = 64;

   // audio bits per subframe, taken from the top of the sample
   localparam int unsigned SPDIF_AUDIO_W = 24;

   // left word sits in the upper half
   typedef struct packed {
      logic [SAMPLE_W-1:0] left;
      logic [SAMPLE_W-1:0] right;
   } stereo_sample_t;

   // receiver alignment states
   typedef enum logic [1:0] {
      RX_IDLE = 2'd0,
      RX_SYNC = 2'd1,
      RX_WORK = 2'd2
   } rx_state_e;

   // preamble cell bytes, one cell per bit, sent MSB first
   typedef enum logic [7:0] {
      PRE_X = 8'b1001_0011,
      PRE_Y = 8'b1001_0110,
      PRE_Z = 8'b1001_1100
   } spdif_preamble_e;

   // consumer channel status, first 24 bits of the block, MSB first
   localparam logic [23:0] DEFAULT_CHANNEL_STATUS = 24'b0010_0000_0000_0000_0100_0000;

endpackage

// ==== src/biphase_encoder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// biphase-mark line coder, one cell per bck, loaded a byte at a time
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module biphase_encoder (
   input  logic       bck,
   input  logic       reset_n,
   input  logic       start_i,
   input  logic [7:0] cells_i,
   input  logic       load_i,
   output logic       spdif_o
);

   logic       clr_n;
   logic [7:0] cell_shift;

   assign clr_n = reset_n & start_i;

   // cell shifter, MSB is the cell on the line next
   always_ff @(posedge bck or negedge clr_n) begin
      if (!clr_n) begin
         cell_shift <= '0;
      end else if (load_i) begin
         cell_shift <= cells_i;
      end else begin
         cell_shift <= {cell_shift[6:0], 1'b0};
      end
   end

   // a 1 cell flips the line, a 0 cell holds it
   always_ff @(posedge bck or negedge clr_n) begin
      if (!clr_n) begin
         spdif_o <= 1'b0;
      end else if (cell_shift[7]) begin
         spdif_o <= ~spdif_o;
      end
   end

endmodule

// ==== src/i2s_rx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2S slave receiver, 32-bit words, 64 bck per frame
// aligns once on the first lrck fall, then free-runs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module i2s_rx import audio_pkg::*; (
   input  logic           bck,
   input  logic           reset_n,
   input  logic           start_i,
   input  logic           lrck_i,
   input  logic           data_i,
   output stereo_sample_t sample_o,
   output logic           sample_valid_o
);

   localparam int unsigned BIT_W = $clog2(FRAME_BITS);

   logic                clr_n;
   logic                lrck_q;
   logic                lrck_fall;
   rx_state_e           state;
   logic [BIT_W-1:0]    bit_cnt;
   logic [SAMPLE_W-1:0] shift_word;
   logic [SAMPLE_W-1:0] left_word;
   logic [SAMPLE_W-1:0] next_word;

   // engine is held clear while start is low
   assign clr_n = reset_n & start_i;

   // left channel begins when lrck drops
   assign lrck_fall = lrck_q & ~lrck_i;
   assign next_word = {shift_word[SAMPLE_W-2:0], data_i};

   always_ff @(posedge bck or negedge clr_n) begin
      if (!clr_n) begin
         lrck_q         <= 1'b0;
         state          <= RX_IDLE;
         bit_cnt        <= '0;
         sample_o       <= '0;
         sample_valid_o <= 1'b0;
      end else begin
         lrck_q         <= lrck_i;
         sample_valid_o <= 1'b0;
         case (state)
            RX_IDLE: begin
               state <= RX_SYNC;
            end
            RX_SYNC: begin
               // next bck carries the left MSB
               if (lrck_fall) begin
                  state   <= RX_WORK;
                  bit_cnt <= '0;
               end
            end
            RX_WORK: begin
               // no realignment after the first frame
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                  sample_o.left  <= left_word;
                  sample_o.right <= next_word;
                  sample_valid_o <= 1'b1;
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   // word assembly, MSB first
   always_ff @(posedge bck) begin
      if (state == RX_WORK) begin
         shift_word <= next_word;
         if (bit_cnt == BIT_W'(SAMPLE_W - 1)) begin
            left_word <= next_word;
         end
      end
   end

   // one publish per 64-bit frame
   a_valid_single : assert property (
      @(posedge bck) disable iff (!clr_n)
      sample_valid_o |=> !sample_valid_o
   ) else $error("i2s_rx: sample_valid_o high for more than one cycle");

endmodule

// ==== src/i2s_tx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2S transmitter, resends the held stereo pair at 64 bck per frame
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module i2s_tx import audio_pkg::*; (
   input  logic           bck,
   input  logic           reset_n,
   input  logic           start_i,
   input  stereo_sample_t sample_i,
   output logic           lrck_o,
   output logic           data_o
);

   localparam int unsigned BIT_W = $clog2(FRAME_BITS);

   logic                  clr_n;
   logic [BIT_W-1:0]      cnt;
   logic [2*SAMPLE_W-1:0] shift_frame;

   assign clr_n = reset_n & start_i;

   // low half of the frame is left
   assign lrck_o = cnt[BIT_W-1];

   always_ff @(posedge bck or negedge clr_n) begin
      if (!clr_n) begin
         cnt         <= '0;
         shift_frame <= '0;
         data_o      <= 1'b0;
      end else begin
         cnt <= cnt + 1'b1;
         // pick up the latest pair just before the frame wraps
         if (cnt == BIT_W'(FRAME_BITS - 1)) begin
            shift_frame <= sample_i;
         end else begin
            shift_frame <= {shift_frame[2*SAMPLE_W-2:0], 1'b0};
         end
         // one bck behind lrck, as I2S expects
         data_o <= shift_frame[2*SAMPLE_W-1];
      end
   end

   a_lrck_edges : assert property (
      @(posedge bck) disable iff (!clr_n)
      $changed(lrck_o) |-> (cnt == '0 || cnt == BIT_W'(FRAME_BITS / 2))
   ) else $error("i2s_tx: lrck_o moved away from a half-frame boundary");

endmodule

// ==== src/pcm_bridge_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PCM bridge top, I2S in, I2S and S/PDIF out, all on bck
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pcm_bridge_top import audio_pkg::*; #(
   parameter int unsigned BLOCK_FRAMES   = 192,
   parameter logic [23:0] CHANNEL_STATUS = DEFAULT_CHANNEL_STATUS
) (
   input  logic           bck,
   input  logic           reset_n,
   input  logic           start_i,
   input  logic           i2s_lrck_i,
   input  logic           i2s_data_i,
   output stereo_sample_t sample_o,
   output logic           sample_valid_o,
   output logic           i2s_lrck_o,
   output logic           i2s_data_o,
   output logic           spdif_o
);

   logic [7:0] cells;
   logic       cell_load;

   i2s_rx i2s_rx_inst (
      .bck            (bck),
      .reset_n        (reset_n),
      .start_i        (start_i),
      .lrck_i         (i2s_lrck_i),
      .data_i         (i2s_data_i),
      .sample_o       (sample_o),
      .sample_valid_o (sample_valid_o)
   );

   i2s_tx i2s_tx_inst (
      .bck      (bck),
      .reset_n  (reset_n),
      .start_i  (start_i),
      .sample_i (sample_o),
      .lrck_o   (i2s_lrck_o),
      .data_o   (i2s_data_o)
   );

   spdif_framer #(
      .BLOCK_FRAMES   (BLOCK_FRAMES),
      .CHANNEL_STATUS (CHANNEL_STATUS)
   ) spdif_framer_inst (
      .bck      (bck),
      .reset_n  (reset_n),
      .start_i  (start_i),
      .sample_i (sample_o),
      .cells_o  (cells),
      .load_o   (cell_load)
   );

   biphase_encoder biphase_encoder_inst (
      .bck     (bck),
      .reset_n (reset_n),
      .start_i (start_i),
      .cells_i (cells),
      .load_i  (cell_load),
      .spdif_o (spdif_o)
   );

endmodule

// ==== src/spdif_framer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// S/PDIF framer, one byte of biphase cells every 8 bck
// feed cells_o/load_o straight into the biphase encoder
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module spdif_framer import audio_pkg::*; #(
   parameter int unsigned BLOCK_FRAMES   = 192,
   parameter logic [23:0] CHANNEL_STATUS = DEFAULT_CHANNEL_STATUS
) (
   input  logic           bck,
   input  logic           reset_n,
   input  logic           start_i,
   input  stereo_sample_t sample_i,
   output logic [7:0]     cells_o,
   output logic           load_o
);

   localparam int unsigned SUBFRAMES = 2 * BLOCK_FRAMES;
   localparam int unsigned SUB_W     = $clog2(SUBFRAMES);
   localparam int unsigned BIT_W     = $clog2(FRAME_BITS);
   localparam int unsigned CS_W      = $bits(CHANNEL_STATUS);

   logic                     clr_n;
   logic [BIT_W-1:0]         bit_cnt;
   logic [SUB_W-1:0]         sub_cnt;
   logic [SPDIF_AUDIO_W-1:0] audio;
   logic [CS_W-1:0]          cs_shift;
   logic                     c_bit;
   logic                     parity;
   logic                     byte_start;
   logic [2:0]               byte_idx;
   spdif_preamble_e          preamble;
   logic [7:0]               next_cells;

   // each audio slot is a clock cell followed by the data cell
   function automatic logic [7:0] slot_cells(input logic [3:0] bits);
      return {1'b1, bits[0], 1'b1, bits[1], 1'b1, bits[2], 1'b1, bits[3]};
   endfunction

   assign clr_n      = reset_n & start_i;
   assign byte_start = (bit_cnt[2:0] == 3'd0);
   assign byte_idx   = bit_cnt[BIT_W-1 -: 3];
   assign c_bit      = cs_shift[CS_W-1];

   // V and U are zero, so only audio and C enter the even parity
   assign parity = ^{audio, c_bit};

   always_comb begin
      if (sub_cnt == '0) begin
         preamble = PRE_Z;
      end else if (!sub_cnt[0]) begin
         preamble = PRE_X;
      end else begin
         preamble = PRE_Y;
      end
   end

   always_comb begin
      case (byte_idx)
         3'd0:    next_cells = preamble;
         3'd1:    next_cells = slot_cells(audio[3:0]);
         3'd2:    next_cells = slot_cells(audio[7:4]);
         3'd3:    next_cells = slot_cells(audio[11:8]);
         3'd4:    next_cells = slot_cells(audio[15:12]);
         3'd5:    next_cells = slot_cells(audio[19:16]);
         3'd6:    next_cells = slot_cells(audio[23:20]);
         // V, U, C, P
         default: next_cells = {1'b1, 1'b0, 1'b1, 1'b0, 1'b1, c_bit, 1'b1, parity};
      endcase
   end

   always_ff @(posedge bck or negedge clr_n) begin
      if (!clr_n) begin
         bit_cnt  <= '0;
         sub_cnt  <= '0;
         cs_shift <= '0;
         cells_o  <= '0;
         load_o   <= 1'b0;
      end else begin
         bit_cnt <= bit_cnt + 1'b1;
         load_o  <= byte_start;
         if (byte_start) begin
            cells_o <= next_cells;
         end
         if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
            if (sub_cnt == SUB_W'(SUBFRAMES - 1)) begin
               sub_cnt <= '0;
            end else begin
               sub_cnt <= sub_cnt + 1'b1;
            end
         end
         // status reloads on Z, advances on every other left subframe
         if (bit_cnt == '0) begin
            if (sub_cnt == '0) begin
               cs_shift <= CHANNEL_STATUS;
            end else if (!sub_cnt[0]) begin
               cs_shift <= {cs_shift[CS_W-2:0], 1'b0};
            end
         end
      end
   end

   // latch this subframe's channel word while the preamble goes out
   always_ff @(posedge bck) begin
      if (bit_cnt == '0) begin
         audio <= sub_cnt[0] ? sample_i.right[SAMPLE_W-1 -: SPDIF_AUDIO_W]
                             : sample_i.left[SAMPLE_W-1 -: SPDIF_AUDIO_W];
      end
   end

   a_load_period : assert property (
      @(posedge bck) disable iff (!clr_n)
      load_o |=> (!load_o) [*7] ##1 load_o
   ) else $error("spdif_framer: load_o period is not 8 cycles");

endmodule

// ==== tb/tb_pcm_bridge.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the PCM bridge, drives I2S in and decodes I2S and S/PDIF out
// built and run through the Makefile, the verdict is printed at the end
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_pcm_bridge import audio_pkg::*;;

   localparam int BLOCK_FRAMES    = 192;
   localparam int BLOCK_SUBFRAMES = 2 * BLOCK_FRAMES;
   localparam int BLOCK_CYCLES    = BLOCK_SUBFRAMES * FRAME_BITS;
   localparam int WATCHDOG_CYCLES = 6 * BLOCK_CYCLES + 5000;

   logic           bck;
   logic           reset_n;
   logic           start_i;
   logic           i2s_lrck_i;
   logic           i2s_data_i;
   stereo_sample_t sample_o;
   logic           sample_valid_o;
   logic           i2s_lrck_o;
   logic           i2s_data_o;
   logic           spdif_o;

   stereo_sample_t drive_pair;  // taken by the driver at the next frame start
   stereo_sample_t done_pair;   // pair whose last bit went out most recently
   stereo_sample_t held_pair;
   logic           lrck_q  = 1'b0;
   logic           spdif_q = 1'b0;

   pcm_bridge_top #(
      .BLOCK_FRAMES   (BLOCK_FRAMES),
      .CHANNEL_STATUS (DEFAULT_CHANNEL_STATUS)
   ) pcm_bridge_top_inst (
      .bck            (bck),
      .reset_n        (reset_n),
      .start_i        (start_i),
      .i2s_lrck_i     (i2s_lrck_i),
      .i2s_data_i     (i2s_data_i),
      .sample_o       (sample_o),
      .sample_valid_o (sample_valid_o),
      .i2s_lrck_o     (i2s_lrck_o),
      .i2s_data_o     (i2s_data_o),
      .spdif_o        (spdif_o)
   );

   initial begin
      bck = 1'b0;
      forever #5 bck = ~bck;
   end

   // I2S source, lrck low for left, data one bck behind the lrck edge
   initial begin : i2s_driver
      logic [5:0]     phase;
      stereo_sample_t active;
      phase      = '0;
      active     = '0;
      done_pair  = '0;
      i2s_lrck_i = 1'b0;
      i2s_data_i = 1'b0;
      forever begin
         @(posedge bck);
         #1;
         if (phase == 6'd0) done_pair = active;
         if (phase == 6'd1) active = drive_pair;
         i2s_lrck_i = phase[5];
         // phase 1 sends bit 63, phase 0 closes the frame with the right LSB
         i2s_data_i = active[6'd0 - phase];
         phase = phase + 6'd1;
      end
   end

   // previous-cycle levels for edge and cell detection
   always @(negedge bck) begin
      lrck_q  <= i2s_lrck_o;
      spdif_q <= spdif_o;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge bck);
      fail_now("watchdog expired before the tests finished");
   end

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (actual !== expected) begin
         fail_now($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   function automatic stereo_sample_t random_pair();
      return {$urandom(), $urandom()};
   endfunction

   task automatic wait_valid(input string name, output int n);
      n = 0;
      do begin
         @(negedge bck);
         n++;
         if (n > 3 * FRAME_BITS) fail_now({name, ": sample_valid_o never pulsed"});
      end while (!sample_valid_o);
   endtask

   task automatic read_i2s_frame(input string name, output logic [63:0] frame);
      int n;
      n = 0;
      do begin
         @(negedge bck);
         n++;
         if (n > 2 * FRAME_BITS) fail_now({name, ": i2s_lrck_o stopped toggling"});
      end while (!(lrck_q && !i2s_lrck_o));
      repeat (FRAME_BITS) begin
         @(negedge bck);
         frame = {frame[62:0], i2s_data_o};
      end
   endtask

   // a 1 cell is a level change since the previous cycle
   task automatic next_cell(output logic c);
      @(negedge bck);
      c = spdif_o ^ spdif_q;
   endtask

   task automatic spdif_lock(input string name, input int limit);
      logic [7:0] win;
      logic       c;
      int         n;
      win = '0;
      n   = 0;
      while (win != PRE_Z) begin
         if (n >= limit) fail_now({name, ": no Z preamble found on spdif_o"});
         next_cell(c);
         win = {win[6:0], c};
         n++;
      end
   endtask

   // 24 audio slots then V, U, C, P, each slot a 1 cell and a data cell
   task automatic read_body(input string name, output logic [27:0] slots);
      logic clk_cell;
      logic bit_cell;
      repeat (SPDIF_AUDIO_W + 4) begin
         next_cell(clk_cell);
         next_cell(bit_cell);
         check({name, ": slot clock cell"}, 64'(1), 64'(clk_cell));
         slots = {bit_cell, slots[27:1]};
      end
   endtask

   task automatic read_subframe(input string name, output logic [7:0] pre,
                                output logic [27:0] slots);
      logic c;
      pre = '0;
      repeat (8) begin
         next_cell(c);
         pre = {pre[6:0], c};
      end
      read_body(name, slots);
   endtask

   task automatic check_payload(input string name, input logic is_left,
                                input logic [27:0] slots);
      logic [23:0] audio;
      audio = is_left ? held_pair.left[31:8] : held_pair.right[31:8];
      check({name, ": audio"}, 64'(audio), 64'(slots[23:0]));
      check({name, ": validity and user"}, 64'(0), 64'(slots[25:24]));
      check({name, ": even parity"}, 64'(0), 64'(^slots));
   endtask

   task automatic test_reset_idle();
      repeat (100) begin
         @(negedge bck);
         check("reset_idle: outputs", 64'(0),
               64'({spdif_o, i2s_lrck_o, i2s_data_o, sample_valid_o}));
         check("reset_idle: sample", 64'(0), sample_o);
         check("reset_idle: rx state", 64'(RX_IDLE),
               64'(pcm_bridge_top_inst.i2s_rx_inst.state));
      end
   endtask

   task automatic test_capture();
      stereo_sample_t last;
      int             n;
      drive_pair = random_pair();
      @(posedge bck);
      #1 start_i = 1'b1;
      wait_valid("capture", n);
      check("capture: first pair", done_pair, sample_o);
      repeat (6) begin
         last       = random_pair();
         drive_pair = last;
         wait_valid("capture", n);
         check("capture: spacing", 64'(FRAME_BITS), 64'(n));
         check("capture: pair", done_pair, sample_o);
      end
      // a new pair shows up two frames after it is queued
      repeat (2) begin
         wait_valid("capture", n);
         check("capture: spacing", 64'(FRAME_BITS), 64'(n));
      end
      check("capture: last pair", last, sample_o);
   endtask

   task automatic test_i2s_retransmit();
      logic [63:0] frame;
      int          n;
      held_pair  = random_pair();
      drive_pair = held_pair;
      repeat (2) wait_valid("retransmit", n);
      check("retransmit: capture", held_pair, sample_o);
      repeat (3) begin
         read_i2s_frame("retransmit", frame);
         check("retransmit: frame", held_pair, frame);
      end
   endtask

   task automatic test_spdif_payload();
      logic [7:0]  pre;
      logic [27:0] slots;
      spdif_lock("payload", BLOCK_CYCLES + 2 * FRAME_BITS);
      read_body("payload", slots);
      check_payload("payload Z", 1'b1, slots);
      for (int k = 1; k < 16; k++) begin
         read_subframe("payload", pre, slots);
         check("payload: preamble", 64'((k % 2 != 0) ? PRE_Y : PRE_X), 64'(pre));
         check_payload("payload", k % 2 == 0, slots);
      end
   endtask

   task automatic test_spdif_blocks();
      logic [7:0]  pre;
      logic [27:0] slots;
      logic [23:0] status;
      logic        is_left;
      status = DEFAULT_CHANNEL_STATUS;
      spdif_lock("blocks", BLOCK_CYCLES + 2 * FRAME_BITS);
      read_body("blocks", slots);
      check("blocks: status bit", 64'(status[23]), 64'(slots[26]));
      status = status << 1;
      for (int k = 1; k <= BLOCK_SUBFRAMES; k++) begin
         read_subframe("blocks", pre, slots);
         is_left = (k % 2 == 0);
         if (k == BLOCK_SUBFRAMES) begin
            check("blocks: Z preamble", 64'(PRE_Z), 64'(pre));
            check("blocks: status reload", 64'(DEFAULT_CHANNEL_STATUS[23]), 64'(slots[26]));
         end else if (is_left) begin
            check("blocks: X preamble", 64'(PRE_X), 64'(pre));
            // status bits run MSB first over left subframes, then zeros
            check("blocks: status bit", 64'(status[23]), 64'(slots[26]));
            status = status << 1;
         end else begin
            check("blocks: Y preamble", 64'(PRE_Y), 64'(pre));
         end
         check_payload("blocks", is_left, slots);
      end
   endtask

   task automatic test_stop_restart();
      stereo_sample_t pair;
      logic [63:0]    frame;
      int             n;
      pair       = random_pair();
      drive_pair = pair;
      @(posedge bck);
      #1 start_i = 1'b0;
      repeat (100) begin
         @(negedge bck);
         check("restart: stopped outputs", 64'(0),
               64'({spdif_o, i2s_lrck_o, i2s_data_o, sample_valid_o}));
         check("restart: stopped sample", 64'(0), sample_o);
      end
      @(posedge bck);
      #1 start_i = 1'b1;
      // a fresh block opens with Z straight away
      spdif_lock("restart", 2 * FRAME_BITS);
      wait_valid("restart", n);
      check("restart: capture", pair, sample_o);
      read_i2s_frame("restart", frame);
      check("restart: retransmit", pair, frame);
   endtask

   initial begin : main
      logic [31:0] seed_ret;
      reset_n    = 1'b0;
      start_i    = 1'b0;
      drive_pair = '0;
      held_pair  = '0;
      seed_ret   = $urandom(32'h20f25159);
      repeat (5) @(posedge bck);
      #1 reset_n = 1'b1;
      test_reset_idle();
      test_capture();
      test_i2s_retransmit();
      test_spdif_payload();
      test_spdif_blocks();
      test_stop_restart();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule
